// ==== mix.f ====
+incdir+.
rtl/mix_pkg.sv
rtl/lane_if.sv
rtl/adder_stage.sv
rtl/channel_pipe.sv
rtl/channel_array.sv
rtl/tap_line.sv
rtl/mix_top.sv
test/clk_gen.sv
test/mix_tb.sv

// ==== mix_defs.svh ====
// Global sizes for the five-lane mixing pipeline.

`ifndef MIX_DEFS_SVH
`define MIX_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MIX_WIDTH 32 // Bits per data word.

`define MIX_CHANNELS 5 // Lanes in the tap line, one channel each.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MIX_STAGES 4 // Registered adder stages in every channel.

`endif

// ==== rtl/adder_stage.sv ====
// Registered stage that adds a word to its one-bit left rotation.

`include "mix_defs.svh"

module adder_stage
	import mix_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t data_in,
	output word_t data_out
);

	word_t opnd_a;
	word_t opnd_b;
	word_t sum;
	logic [`MIX_WIDTH-1:0] carry; // Carry into each bit position.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operands
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign opnd_a = data_in;
	assign opnd_b = {data_in[`MIX_WIDTH-2:0], data_in[`MIX_WIDTH-1]}; // Rotate left by one.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Ripple carry chain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign carry[0] = 1'b0;

	for (genvar i = 0; i < `MIX_WIDTH; i++) begin : g_cell
		// Sum bit of one full-adder cell.
		assign sum[i] = opnd_a[i] ^ opnd_b[i] ^ carry[i];

		// The top cell has no carry out, so the result wraps modulo 2^W.
		if (i < `MIX_WIDTH - 1) begin : g_carry
			assign carry[i+1] = (opnd_a[i] & opnd_b[i]) |
					    (carry[i] & (opnd_a[i] ^ opnd_b[i]));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_out <= '0;
		end else begin
			data_out <= sum; // One cycle of latency per stage.
		end
	end

endmodule

// ==== rtl/channel_array.sv ====
// Parallel channel pipes, one per lane, with the exclusive-or fold of their results.

`include "mix_defs.svh"

module channel_array
	import mix_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	lane_if.sink  lanes,
	output word_t folded
);

	word_t chan_out [`MIX_CHANNELS]; // Result of each channel.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channels
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar c = 0; c < `MIX_CHANNELS; c++) begin : g_channel
		channel_pipe i_channel_pipe (
			.clk      (clk),
			.rst      (rst),
			.data_in  (lanes.words[c]),
			.data_out (chan_out[c])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fold
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Combinational, so the fold adds no cycle after the last stage.
	always_comb begin
		folded = '0;
		for (int c = 0; c < `MIX_CHANNELS; c++) begin
			folded = folded ^ chan_out[c];
		end
	end

endmodule

// ==== rtl/channel_pipe.sv ====
// One lane channel built from a chain of registered adder stages.

`include "mix_defs.svh"

module channel_pipe
	import mix_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t data_in,
	output word_t data_out
);

	// Entry s is the input of stage s.
	// The last entry is the channel result.
	word_t stage_w [`MIX_STAGES+1];

	assign stage_w[0] = data_in;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage chain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar s = 0; s < `MIX_STAGES; s++) begin : g_stage
		adder_stage i_adder_stage (
			.clk      (clk),
			.rst      (rst),
			.data_in  (stage_w[s]),
			.data_out (stage_w[s+1])
		);
	end

	// Four words are in flight, one per stage.
	assign data_out = stage_w[`MIX_STAGES];

endmodule

// ==== rtl/lane_if.sv ====
// Lane bus that carries the captured history words from the tap line to the channels.

interface lane_if
	import mix_pkg::*;
	();

	// A fresh set of lane words is presented on every clock.
	// No handshake goes with them.
	lane_array_t words;

	// The tap line drives the lane words.
	modport source (
		output words
	);

	// The channel array consumes the lane words.
	modport sink (
		input words
	);

endinterface

// ==== rtl/mix_pkg.sv ====
// Shared data types for the mixing pipeline datapath.

`include "mix_defs.svh"

package mix_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One stream word as it moves through the tap line and the channels.
	typedef logic [`MIX_WIDTH-1:0] word_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One word per lane.
	// Lane 0 holds the newest input and the last lane holds the oldest.
	typedef word_t lane_array_t [`MIX_CHANNELS];

endpackage

// ==== rtl/mix_top.sv ====
// Top level of the five-lane mixing pipeline, from the input stream to the folded output.

module mix_top
	import mix_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in,
	output word_t out
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	lane_if i_lane_if ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tap line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	tap_line i_tap_line (
		.clk   (clk),
		.rst   (rst),
		.in    (in),
		.lanes (i_lane_if.source)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channels and fold
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The output follows an input word five edges after it is sampled.
	channel_array i_channel_array (
		.clk    (clk),
		.rst    (rst),
		.lanes  (i_lane_if.sink),
		.folded (out)
	);

endmodule

// ==== rtl/tap_line.sv ====
// Five-word input history with the capture register that drives the lane bus.

`include "mix_defs.svh"

module tap_line
	import mix_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  word_t  in,
	lane_if.source lanes
);

	lane_array_t history; // Slot 0 holds the newest word.
	lane_array_t capture; // Snapshot of the history one cycle later.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int j = 0; j < `MIX_CHANNELS; j++) begin
				history[j] <= '0;
			end
		end else begin
			history[0] <= in;
			for (int j = 1; j < `MIX_CHANNELS; j++) begin
				history[j] <= history[j-1]; // Older words move up one slot.
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The whole history is copied every cycle.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int j = 0; j < `MIX_CHANNELS; j++) begin
				capture[j] <= '0;
			end
		end else begin
			capture <= history;
		end
	end

	assign lanes.words = capture; // Lane j carries the word sampled j cycles earlier.

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the mixing pipeline testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timing -f mix.f --top-module mix_tb -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

"./$OBJ/Vmix_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi

// ==== test/clk_gen.sv ====
// Testbench clock source with a power-on reset that can also be pulsed on request.

module clk_gen (
	input  logic rst_req,
	output logic clk,
	output logic rst
);

	logic por_rst;

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk; // Period of 10.
		end
	end

	initial begin
		por_rst = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		por_rst = 1'b0; // Released on a falling edge, half a period before sampling.
	end

	assign rst = por_rst | rst_req;

endmodule

// ==== test/mix_tb.sv ====
// Testbench for the mixing pipeline with a history model and checking assertions.

`include "mix_defs.svh"

module mix_tb
	import mix_pkg::*;
();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run length
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int RESET_CYCLES   = 16;
	localparam int IDLE_CYCLES    = 20;
	localparam int PULSE_COUNT    = 4;
	localparam int PULSE_GAP      = 15;
	localparam int RANDOM_CYCLES  = 400;
	localparam int FIXED_CORNERS  = 8;
	localparam int CORNER_CYCLES  = 120;
	localparam int PRE_RST_CYCLES = 60;
	localparam int MID_RST_HOLD   = 3;
	localparam int POST_ZERO      = 20;
	localparam int POST_RANDOM    = 200;
	localparam int DRAIN_CYCLES   = 12;
	localparam int STIM_CYCLES    = IDLE_CYCLES + PULSE_COUNT * (PULSE_GAP + 1) +
					RANDOM_CYCLES + FIXED_CORNERS + CORNER_CYCLES +
					PRE_RST_CYCLES + MID_RST_HOLD + 1 + POST_ZERO +
					POST_RANDOM + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RESET_CYCLES;

	logic        clk;
	logic        rst;
	logic        rst_req;
	word_t       stim_word;
	word_t       dut_out;
	logic [31:0] lcg_state = 32'had55911c;
	int          cycle = 0;
	logic        idle_phase; // Input held at zero with a cleared pipeline.
	logic        pulse_active;
	word_t       pulse_word;
	int          pulse_edge; // Cycle count after the edge that samples the pulse.
	logic        pulse_window;
	word_t       samples [10]; // Entry i is the input sampled i edges ago.
	word_t       model_out;
	word_t       corner_words [FIXED_CORNERS] = '{
		32'hffff_ffff, 32'hffff_fffe, 32'h8000_0000, 32'h8000_0001,
		32'h7fff_ffff, 32'hc000_0000, 32'haaaa_aaaa, 32'h5555_5555
	};

	clk_gen i_clk_gen (
		.rst_req (rst_req),
		.clk     (clk),
		.rst     (rst)
	);

	mix_top i_mix_top (
		.clk (clk),
		.rst (rst),
		.in  (stim_word),
		.out (dut_out)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic word_t stage_fn(input word_t x);
		return x + ((x << 1) | (x >> (`MIX_WIDTH - 1))); // Sum with the left rotation.
	endfunction

	function automatic word_t channel_fn(input word_t x);
		word_t v;
		v = x;
		for (int s = 0; s < `MIX_STAGES; s++) begin
			v = stage_fn(v);
		end
		return v;
	endfunction

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 10; i++) begin
				samples[i] <= '0;
			end
		end else begin
			samples[0] <= stim_word;
			for (int i = 1; i < 10; i++) begin
				samples[i] <= samples[i-1];
			end
		end
	end

	// An input reaches the output five edges after it is sampled and stays for five.
	always_comb begin
		model_out = '0;
		for (int j = 0; j < `MIX_CHANNELS; j++) begin
			model_out = model_out ^ channel_fn(samples[5+j]);
		end
	end

	always_ff @(posedge clk) begin
		cycle <= cycle + 1;
	end

	assign pulse_window = pulse_active && (cycle >= pulse_edge + 5) &&
			      (cycle <= pulse_edge + 9);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	a_reset_zero: assert property (@(posedge clk) rst |-> dut_out == '0)
		else report_error($sformatf("out is %h during reset", $sampled(dut_out)));

	a_idle_zero: assert property (@(posedge clk) idle_phase |-> dut_out == '0)
		else report_error($sformatf("out is %h with zero input", $sampled(dut_out)));

	a_pulse_on: assert property (@(posedge clk) pulse_window |->
				     dut_out == channel_fn(pulse_word))
		else report_error($sformatf("pulse out %h, expected %h", $sampled(dut_out),
					    channel_fn(pulse_word)));

	a_pulse_off: assert property (@(posedge clk) (pulse_active && !pulse_window) |->
				      dut_out == '0)
		else report_error($sformatf("out %h outside the pulse window", $sampled(dut_out)));

	a_model_match: assert property (@(posedge clk) !rst |-> dut_out == model_out)
		else report_error($sformatf("out %h, model expects %h", $sampled(dut_out),
					    $sampled(model_out)));

	always @(posedge clk) begin
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", cycle);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_word(input word_t w);
		@(negedge clk);
		stim_word = w;
	endtask

	task automatic drive_zeros(input int n);
		repeat (n) drive_word('0);
	endtask

	task automatic drive_random(input int n);
		repeat (n) drive_word(next_random());
	endtask

	task automatic send_pulse(input word_t x);
		@(negedge clk);
		stim_word    = x;
		pulse_word   = x;
		pulse_edge   = cycle + 1; // Sampled at the next rising edge.
		pulse_active = 1'b1;
		drive_zeros(PULSE_GAP);
	endtask

	task automatic drive_corners(input int n);
		word_t r;
		foreach (corner_words[i]) begin
			drive_word(corner_words[i]);
		end
		for (int i = 0; i < n; i++) begin
			r = next_random();
			if (i % 2 == 0) begin
				drive_word(r | 32'h8000_0000);
			end else begin
				drive_word(~(r & 32'h0000_00ff)); // Close to all ones.
			end
		end
	endtask

	task automatic apply_mid_reset();
		@(negedge clk);
		rst_req    = 1'b1;
		stim_word  = '0;
		idle_phase = 1'b1;
		#1;
		assert (dut_out == '0)
			else report_error($sformatf("out %h right after reset", dut_out));
		repeat (MID_RST_HOLD) @(negedge clk);
		rst_req = 1'b0;
	endtask

	initial begin
		stim_word    = '0;
		rst_req      = 1'b0;
		idle_phase   = 1'b1;
		pulse_active = 1'b0;
		pulse_word   = '0;
		pulse_edge   = 0;
		@(negedge rst);

		drive_zeros(IDLE_CYCLES);
		@(negedge clk);
		idle_phase = 1'b0;

		send_pulse(32'h0000_0001);
		send_pulse(32'h8000_0000);
		send_pulse(32'hffff_ffff);
		send_pulse(next_random());
		pulse_active = 1'b0;

		drive_random(RANDOM_CYCLES);
		drive_corners(CORNER_CYCLES);

		drive_random(PRE_RST_CYCLES);
		apply_mid_reset();
		drive_zeros(POST_ZERO);
		idle_phase = 1'b0;
		drive_random(POST_RANDOM);
		drive_zeros(DRAIN_CYCLES);

		$display("Simulation PASSED");
		$finish;
	end

endmodule
